// ==== rtl/pinball_config.svh ====
`ifndef PINBALL_CONFIG_SVH
`define PINBALL_CONFIG_SVH

`define FRAME_CYCLES	64	// short frame so simulation stays quick.
`define FIXED_SCALE		64	// positions and speeds carry 6 fraction bits.

`define FIELD_W			640
`define FIELD_H			480

`define BALL_SIZE		16
`define FLIPPER_Y		440	// top row of the flipper.
`define FLIPPER_W		64
`define FLIPPER_STEP	8	// pixels per frame while a key is held.

`define BALL_INIT_X		280
`define BALL_INIT_Y		185
`define BALL_INIT_VY	100	// in 1/64 pixel per frame.
`define GRAVITY			2
`define FLIPPER_INIT_X	288

`endif

// ==== rtl/pinball_pkg.sv ====
package pinball_pkg;

	// screen coordinate in whole pixels, wide enough for a little overshoot past the walls.
	typedef logic signed [10:0] coord_t;

	// velocity in 1/64 pixel per frame.
	typedef logic signed [31:0] velocity_t;

	// position in 1/64 pixel.
	typedef logic signed [31:0] fixedPos_t;

endpackage

// ==== rtl/collisionIf.sv ====
`timescale 1ns/100ps

interface collisionIf;

	logic hitTop;
	logic hitLeft;
	logic hitRight;
	logic hitFlipper;

	modport detector (
		output hitTop,
		output hitLeft,
		output hitRight,
		output hitFlipper
	);

	modport ball (
		input hitTop,
		input hitLeft,
		input hitRight,
		input hitFlipper
	);

endinterface

// ==== rtl/frameTimer.sv ====
`timescale 1ns/100ps
`include "pinball_config.svh"

module frameTimer (
	input	logic	clk,
	input	logic	resetN,
	output	logic	frameStart
);

	localparam int CNT_W = $clog2(`FRAME_CYCLES);

	logic [CNT_W-1:0] cycleCount;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cycleCount <= '0;
			frameStart <= 1'b0;
		end else begin
			if (cycleCount == CNT_W'(`FRAME_CYCLES - 1)) begin
				cycleCount <= '0;
				frameStart <= 1'b1;	// one pulse per wrap.
			end else begin
				cycleCount <= cycleCount + 1'b1;
				frameStart <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/flipperController.sv ====
`timescale 1ns/100ps
`include "pinball_config.svh"

module flipperController (
	input	logic					clk,
	input	logic					resetN,
	input	logic					frameStart,
	input	logic					pause,
	input	logic					keyLeft,
	input	logic					keyRight,
	output	pinball_pkg::coord_t	flipperX,
	output	pinball_pkg::velocity_t	flipperSpeed
);

	import pinball_pkg::*;

	localparam int MAX_X = `FIELD_W - `FLIPPER_W;
	localparam velocity_t STEP_SPEED = velocity_t'(`FLIPPER_STEP * `FIXED_SCALE);

	int target;

	// next position, clamped so the flipper never leaves the playfield.
	always_comb begin
		target = int'(flipperX);
		if (keyRight && !keyLeft) begin
			target = target + `FLIPPER_STEP;
		end else if (keyLeft && !keyRight) begin
			target = target - `FLIPPER_STEP;
		end
		if (target < 0) begin
			target = 0;
		end else if (target > MAX_X) begin
			target = MAX_X;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			flipperX <= coord_t'(`FLIPPER_INIT_X);
			flipperSpeed <= '0;
		end else if (frameStart) begin
			if (pause) begin
				flipperSpeed <= '0;
			end else begin
				flipperX <= coord_t'(target);
				if (target > int'(flipperX)) begin
					flipperSpeed <= STEP_SPEED;
				end else if (target < int'(flipperX)) begin
					flipperSpeed <= -STEP_SPEED;
				end else begin
					flipperSpeed <= '0;	// blocked at a wall or no single key held.
				end
			end
		end
	end

endmodule

// ==== rtl/collisionDetector.sv ====
`timescale 1ns/100ps
`include "pinball_config.svh"

module collisionDetector (
	input	logic					clk,
	input	logic					resetN,
	input	pinball_pkg::coord_t	ballX,
	input	pinball_pkg::coord_t	ballY,
	input	pinball_pkg::coord_t	flipperX,
	collisionIf.detector			hits
);

	int ballRight;
	int ballBottom;
	int flipperRight;
	logic overTop;
	logic overLeft;
	logic overRight;
	logic overFlipper;

	always_comb begin
		ballRight = int'(ballX) + `BALL_SIZE;
		ballBottom = int'(ballY) + `BALL_SIZE;
		flipperRight = int'(flipperX) + `FLIPPER_W;
	end

	// plain geometry, the direction of travel is judged by the ball itself.
	always_comb begin
		overTop = (int'(ballY) <= 0);
		overLeft = (int'(ballX) <= 0);
		overRight = (ballRight >= `FIELD_W);
		overFlipper = (ballBottom >= `FLIPPER_Y)
			&& (ballRight > int'(flipperX))
			&& (int'(ballX) < flipperRight);
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			hits.hitTop <= 1'b0;
			hits.hitLeft <= 1'b0;
			hits.hitRight <= 1'b0;
			hits.hitFlipper <= 1'b0;
		end else begin
			hits.hitTop <= overTop;
			hits.hitLeft <= overLeft;
			hits.hitRight <= overRight;
			hits.hitFlipper <= overFlipper;
		end
	end

endmodule

// ==== rtl/ballController.sv ====
`timescale 1ns/100ps
`include "pinball_config.svh"

module ballController (
	input	logic					clk,
	input	logic					resetN,
	input	logic					frameStart,
	input	logic					pause,
	input	pinball_pkg::velocity_t	flipperSpeed,
	collisionIf.ball				hits,
	output	pinball_pkg::coord_t	ballX,
	output	pinball_pkg::coord_t	ballY
);

	import pinball_pkg::*;

	localparam fixedPos_t INIT_POS_X = fixedPos_t'(`BALL_INIT_X * `FIXED_SCALE);
	localparam fixedPos_t INIT_POS_Y = fixedPos_t'(`BALL_INIT_Y * `FIXED_SCALE);

	logic started;
	velocity_t velX;
	velocity_t velY;
	fixedPos_t posX;
	fixedPos_t posY;

	// the ball launches on the first running cycle after reset.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			started <= 1'b0;
		end else if (!pause && !started) begin
			started <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			velY <= '0;
			posY <= INIT_POS_Y;
		end else if (!pause) begin
			if (!started) begin
				velY <= velocity_t'(`BALL_INIT_VY);
			end else begin
				if (hits.hitTop && (velY < 0)) begin
					velY <= -velY;
				end else if (hits.hitFlipper && (velY > 0)) begin
					velY <= -velY;
				end
				// a strobe overrides any reflection in the same cycle.
				if (frameStart) begin
					posY <= posY + velY;
					velY <= velY + velocity_t'(`GRAVITY);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			velX <= '0;
			posX <= INIT_POS_X;
		end else if (!pause) begin
			if (!started) begin
				velX <= '0;
			end else begin
				if (hits.hitLeft && (velX < 0)) begin
					velX <= -velX;
				end else if (hits.hitRight && (velX > 0)) begin
					velX <= -velX;
				end else if (hits.hitFlipper && (velY > 0)) begin
					velX <= velX + flipperSpeed;	// flipper motion gives the ball spin.
				end
				if (frameStart) begin
					posX <= posX + velX;
				end
			end
		end
	end

	assign ballX = coord_t'(posX / `FIXED_SCALE);
	assign ballY = coord_t'(posY / `FIXED_SCALE);

endmodule

// ==== rtl/pinballCore.sv ====
`timescale 1ns/100ps

module pinballCore (
	input	logic					clk,
	input	logic					resetN,
	input	logic					pause,
	input	logic					keyLeft,
	input	logic					keyRight,
	output	logic					frameStart,
	output	pinball_pkg::coord_t	ballX,
	output	pinball_pkg::coord_t	ballY,
	output	pinball_pkg::coord_t	flipperX
);

	import pinball_pkg::*;

	velocity_t flipperSpeed;

	collisionIf hitsIf ();

	frameTimer frameTimer_i (
		.clk		(clk),
		.resetN		(resetN),
		.frameStart	(frameStart)
	);

	flipperController flipperController_i (
		.clk			(clk),
		.resetN			(resetN),
		.frameStart		(frameStart),
		.pause			(pause),
		.keyLeft		(keyLeft),
		.keyRight		(keyRight),
		.flipperX		(flipperX),
		.flipperSpeed	(flipperSpeed)
	);

	collisionDetector collisionDetector_i (
		.clk		(clk),
		.resetN		(resetN),
		.ballX		(ballX),
		.ballY		(ballY),
		.flipperX	(flipperX),
		.hits		(hitsIf.detector)
	);

	ballController ballController_i (
		.clk			(clk),
		.resetN			(resetN),
		.frameStart		(frameStart),
		.pause			(pause),
		.flipperSpeed	(flipperSpeed),
		.hits			(hitsIf.ball),
		.ballX			(ballX),
		.ballY			(ballY)
	);

endmodule

// ==== tests/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
	output	logic	clk,
	output	logic	resetN
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period.
	end

	initial begin
		resetN = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;
	end

endmodule

// ==== tests/pinballCore_properties.sv ====
`timescale 1ns/100ps
`include "pinball_config.svh"

module pinballCore_properties (
	input	logic					clk,
	input	logic					resetN,
	input	logic					pause,
	input	logic					frameStart,
	input	pinball_pkg::coord_t	ballX,
	input	pinball_pkg::coord_t	ballY,
	input	pinball_pkg::coord_t	flipperX
);

	import pinball_pkg::*;

	strobeWidth: assert property (@(posedge clk) disable iff (!resetN)
		frameStart |=> !frameStart)
		else $error("frameStart stayed high for two cycles");

	// on the first edge after reset every output still sits at its start value.
	resetValues: assert property (@(posedge clk)
		$rose(resetN) |-> (ballX == coord_t'(`BALL_INIT_X)) && (ballY == coord_t'(`BALL_INIT_Y))
			&& (flipperX == coord_t'(`FLIPPER_INIT_X)) && !frameStart)
		else $error("outputs differ from their initial values after reset");

	pauseFreeze: assert property (@(posedge clk) disable iff (!resetN)
		($past(pause) && $past(resetN)) |-> ($stable(ballX) && $stable(ballY)))
		else $error("ball moved while pause was high");

endmodule

// ==== tests/pinballCore_tb.sv ====
`timescale 1ns/100ps
`include "pinball_config.svh"

module pinballCore_tb;

	import pinball_pkg::*;

	localparam int WAIT_LIMIT = 2 * `FRAME_CYCLES;
	localparam int MAX_X = `FIELD_W - `FLIPPER_W;
	localparam int STEP_SPEED = `FLIPPER_STEP * `FIXED_SCALE;

	logic clk;
	logic resetN;
	logic pause;
	logic keyLeft;
	logic keyRight;
	logic frameStart;
	coord_t ballX;
	coord_t ballY;
	coord_t flipperX;

	int errors;
	logic [31:0] lfsr;

	// reference model state, positions and speeds in 1/64 pixel.
	int mPosX;
	int mPosY;
	int mVx;
	int mVy;
	int mFlipX;
	int mFlipSpeed;
	bit mStarted;

	clockGen clockGen_i (.clk(clk), .resetN(resetN));

	pinballCore pinballCore_i (
		.clk		(clk),
		.resetN		(resetN),
		.pause		(pause),
		.keyLeft	(keyLeft),
		.keyRight	(keyRight),
		.frameStart	(frameStart),
		.ballX		(ballX),
		.ballY		(ballY),
		.flipperX	(flipperX)
	);

	bind pinballCore pinballCore_properties properties_i (
		.clk		(clk),
		.resetN		(resetN),
		.pause		(pause),
		.frameStart	(frameStart),
		.ballX		(ballX),
		.ballY		(ballY),
		.flipperX	(flipperX)
	);

	// fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int randomBits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			value = (value << 1) | lfsr[0];
		end
		return value;
	endfunction

	task automatic checkCoord(input string name, input coord_t got, input coord_t expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h expected 0x%h", name, got, expected);
			errors++;
		end
	endtask

	task automatic checkStrobe(input int got, input int expected);
		if (got != expected) begin
			$display("FAIL frameStart spacing: got 0x%h expected 0x%h", got, expected);
			errors++;
		end
	endtask

	task automatic finishRun();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// one frame of the game rules, with the inputs held over that frame.
	task automatic modelFrame();
		int target;
		int bx;
		int by;
		bit hitT;
		bit hitL;
		bit hitR;
		bit hitF;
		int oldVy;
		if (pause) begin
			mFlipSpeed = 0;
		end else begin
			target = mFlipX;
			if (keyRight && !keyLeft) target = target + `FLIPPER_STEP;
			if (keyLeft && !keyRight) target = target - `FLIPPER_STEP;
			if (target < 0) target = 0;
			if (target > MAX_X) target = MAX_X;
			mFlipSpeed = (target > mFlipX) ? STEP_SPEED : (target < mFlipX) ? -STEP_SPEED : 0;
			mFlipX = target;
		end
		if (!pause && mStarted) begin
			mPosX = mPosX + mVx;
			mPosY = mPosY + mVy;
			mVy = mVy + `GRAVITY;
			bx = mPosX / `FIXED_SCALE;
			by = mPosY / `FIXED_SCALE;
			hitT = (by <= 0);
			hitL = (bx <= 0);
			hitR = (bx + `BALL_SIZE >= `FIELD_W);
			hitF = (by + `BALL_SIZE >= `FLIPPER_Y) && (bx + `BALL_SIZE > mFlipX)
				&& (bx < mFlipX + `FLIPPER_W);
			oldVy = mVy;
			if (hitT && mVy < 0) mVy = -mVy;
			else if (hitF && mVy > 0) mVy = -mVy;
			if (hitL && mVx < 0) mVx = -mVx;
			else if (hitR && mVx > 0) mVx = -mVx;
			else if (hitF && oldVy > 0) mVx = mVx + mFlipSpeed;	// spin from the flipper.
		end
	endtask

	task automatic releasePause();
		pause = 1'b0;
		if (!mStarted) begin
			mStarted = 1'b1;
			mVy = `BALL_INIT_VY;
			mVx = 0;
		end
	endtask

	// waits for the strobe, steps the model and compares two cycles later.
	task automatic runFrame(output int spacing);
		int count;
		count = 0;
		while (!frameStart && count < WAIT_LIMIT) begin
			@(negedge clk);
			count++;
		end
		if (!frameStart) begin
			$display("timeout: no frameStart within %0d cycles", WAIT_LIMIT);
			errors++;
			$display("errors: %0d", errors);
			$display("Test failed");
			$finish;
		end else begin
			modelFrame();
			repeat (2) @(negedge clk);
			spacing = count + 2;
			checkCoord("ballX", ballX, coord_t'(mPosX / `FIXED_SCALE));
			checkCoord("ballY", ballY, coord_t'(mPosY / `FIXED_SCALE));
			checkCoord("flipperX", flipperX, coord_t'(mFlipX));
		end
	endtask

	task automatic runFrames(input int n);
		int spacing;
		for (int i = 0; i < n; i++) begin
			runFrame(spacing);
		end
	endtask

	task automatic testResetPause();
		int spacing;
		runFrame(spacing);	// first spacing is measured from an arbitrary point.
		for (int i = 0; i < 4; i++) begin
			runFrame(spacing);
			checkStrobe(spacing, `FRAME_CYCLES);
		end
	endtask

	task automatic testFreeFall();
		releasePause();
		runFrames(6);
		checkCoord("ballX", ballX, coord_t'(`BALL_INIT_X));
	endtask

	task automatic testFlipperKick();
		int n;
		coord_t yAtHit;
		coord_t xAtHit;
		keyLeft = 1'b1;	// park the flipper a little left of the ball.
		runFrames(8);
		keyLeft = 1'b0;
		n = 0;
		while (mPosY / `FIXED_SCALE < 410 && n < 200) begin
			runFrames(1);
			n++;
		end
		keyRight = 1'b1;
		n = 0;
		while (mVy > 0 && n < 20) begin
			runFrames(1);
			n++;
		end
		keyRight = 1'b0;
		if (mVy > 0) begin
			$display("the ball never bounced off the flipper");
			errors++;
		end
		yAtHit = ballY;
		xAtHit = ballX;
		runFrames(4);
		if (ballY >= yAtHit) begin
			$display("the ball did not rise after the flipper hit");
			errors++;
		end
		if (ballX <= xAtHit) begin
			$display("the ball did not drift right after the kick");
			errors++;
		end
	endtask

	task automatic testPauseFlight();
		pause = 1'b1;
		runFrames(3);
		releasePause();
		runFrames(3);
	endtask

	task automatic testWallReflection();
		runFrames(60);	// long run toward the right wall and back.
	endtask

	task automatic testFlipperMotion();
		int guard;
		keyLeft = 1'b1;	// both keys held in mid field leave the flipper where it is.
		keyRight = 1'b1;
		runFrames(2);
		keyLeft = 1'b0;
		keyRight = 1'b0;
		guard = 0;
		while (mFlipX > 0 && guard < 60) begin
			keyLeft = 1'b1;
			runFrames(randomBits(2) + 1);
			keyLeft = 1'b0;
			runFrames(1);
			guard++;
		end
		keyLeft = 1'b1;
		runFrames(2);	// held against the left wall.
		keyLeft = 1'b0;
		guard = 0;
		while (mFlipX < MAX_X && guard < 60) begin
			keyRight = 1'b1;
			runFrames(randomBits(2) + 1);
			keyRight = 1'b0;
			runFrames(1);
			guard++;
		end
		keyRight = 1'b1;
		runFrames(2);
		keyRight = 1'b0;
		checkCoord("flipperX", flipperX, coord_t'(MAX_X));
	endtask

	initial begin
		int count;
		pause = 1'b1;
		keyLeft = 1'b0;
		keyRight = 1'b0;
		errors = 0;
		lfsr = 32'h3d69;
		mPosX = `BALL_INIT_X * `FIXED_SCALE;
		mPosY = `BALL_INIT_Y * `FIXED_SCALE;
		mVx = 0;
		mVy = 0;
		mFlipX = `FLIPPER_INIT_X;
		mFlipSpeed = 0;
		mStarted = 1'b0;
		count = 0;
		while (resetN !== 1'b1 && count < 20) begin
			@(negedge clk);
			count++;
		end
		if (resetN !== 1'b1) begin
			$display("reset was never released");
			errors++;
		end
		testResetPause();
		testFreeFall();
		testFlipperKick();
		testPauseFlight();
		testWallReflection();
		testFlipperMotion();
		finishRun();
	end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/pinball_pkg.sv
rtl/collisionIf.sv
rtl/frameTimer.sv
rtl/flipperController.sv
rtl/collisionDetector.sv
rtl/ballController.sv
rtl/pinballCore.sv
tests/clockGen.sv
tests/pinballCore_properties.sv
tests/pinballCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run the simulation, then decide by searching the log.
rm -f sim.log &&
verilator --binary --assert -Wno-fatal -f project.f --top-module pinballCore_tb \
	-o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
